// ==== neuron_tests.txt ====
# name clear nbeats mask w0 a0 w1 a1 w2 a2 w3 a3 w4 a4 w5 a5 w6 a6 w7 a7 sum sign
# mask and pairs in hex, the rest in decimal, sum is the running total
single_agree  1 1  ffff ffff ffff 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 16 0
single_neg    1 1  ffff 0fff 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 -8 1
multi_masked  1 4  00ff ffff ffff 00ff 0000 f0f0 f00f 1234 1234 0000 ffff 0000 ffff 0000 ffff 0000 ffff 0 0
full_eight    1 8  ffff ffff ffff 0000 0000 ff00 00ff aaaa 5555 aaaa aaaa 000f 0000 00ff 0000 ffff 0000 8 0
accum_add     0 2  0f0f 0000 ffff 0000 0f0f 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 -8 1
accum_more    0 1  ffff 0000 0001 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 6 0
clear_restart 1 3  f000 0000 f000 8000 8000 7000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 -2 1
mask_one      0 5  0001 0001 0001 0000 0001 fffe 0000 0001 0000 ffff ffff 0000 0000 0000 0000 0000 0000 -1 1
nbeats_high   1 15 ffff ffff 0000 ffff 0000 ffff 0000 ffff 0000 ffff 0000 ffff 0000 ffff 0000 ffff 0000 -128 1
nbeats_zero   0 0  ffff 1111 1111 ffff 0000 ffff 0000 ffff 0000 ffff 0000 ffff 0000 ffff 0000 ffff 0000 -112 1

// ==== neuron.f ====
neuron_pkg.sv
vote_selector.sv
vote_counter.sv
beat_sequencer.sv
apb_regs.sv
neuron_top.sv
tb_neuron.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_neuron
FILELIST  ?= neuron.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: $(BIN) neuron_tests.txt
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_neuron.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_neuron;

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    wire  [31:0] prdata;
    wire         pready;
    wire         pslverr;

    // beat data for the current run
    logic [15:0] w_buf [8];
    logic [15:0] a_buf [8];

    // running total the accumulator should hold
    integer model_acc;
    logic [31:0] rng;
    logic [8*24-1:0] cur_name;

    // file fields
    integer fd;
    integer cnt;
    integer t_clear;
    integer t_nb;
    integer t_sum;
    integer t_sign;
    integer exp_sum;
    integer i;
    integer r;
    logic [15:0] t_mask;
    logic [8*256-1:0] line;
    logic [31:0] rd;

    neuron_top uut (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task fail_stop;
        begin
            $display("Test failures found");
            $fatal(1, "stopping at first failure");
        end
    endtask

    // next value of the generator
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        lcg_next = s * 32'd1664525 + 32'd1013904223;
    endfunction

    // votes of one run: +1 agree, -1 disagree, masked lanes silent
    function automatic integer run_votes(input integer nb, input logic [15:0] mask);
        integer beats;
        integer total;
        integer b;
        integer l;
        begin
            beats = (nb < 1) ? 1 : ((nb > 8) ? 8 : nb);
            total = 0;
            for (b = 0; b < beats; b = b + 1) begin
                for (l = 0; l < 16; l = l + 1) begin
                    if (mask[l]) begin
                        total = total + ((w_buf[b][l] == a_buf[b][l]) ? 1 : -1);
                    end
                end
            end
            run_votes = total;
        end
    endfunction

    // one apb transfer, entered and left 1 ns after a rising edge
    task apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                  input logic exp_err, output logic [31:0] rdata);
        integer waits;
        begin
            psel    = 1'b1;
            penable = 1'b0;
            pwrite  = wr;
            paddr   = addr;
            pwdata  = data;
            @(posedge clk);
            #1 penable = 1'b1;
            waits = 0;
            @(negedge clk);
            while (pready !== 1'b1) begin
                if (waits == 16) begin
                    $display("apb access to 0x%02h never completed, pready stuck low", addr);
                    fail_stop();
                end
                waits = waits + 1;
                @(negedge clk);
            end
            rdata = prdata;
            assert (pslverr === exp_err) else begin
                $display("** Error: %0s pslverr at 0x%02h expected %0d, actual %0d",
                         cur_name, addr, exp_err, pslverr);
                fail_stop();
            end
            @(posedge clk);
            #1;
            psel    = 1'b0;
            penable = 1'b0;
        end
    endtask

    task apb_write(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
        logic [31:0] unused;
        begin
            apb_xfer(1'b1, addr, data, exp_err, unused);
        end
    endtask

    task apb_read(input logic [7:0] addr, output logic [31:0] data, input logic exp_err);
        begin
            apb_xfer(1'b0, addr, 32'd0, exp_err, data);
        end
    endtask

    // fill the buffer from w_buf / a_buf and kick off the run
    task load_run(input logic clr, input integer nb, input logic [15:0] mask);
        integer b;
        begin
            if (clr) begin
                apb_write(neuron_pkg::ctrl, 32'd2, 1'b0);
            end
            apb_write(neuron_pkg::nbeats, nb, 1'b0);
            apb_write(neuron_pkg::mask, {16'd0, mask}, 1'b0);
            apb_write(neuron_pkg::buf_addr, 32'd0, 1'b0);
            for (b = 0; b < 8; b = b + 1) begin
                apb_write(neuron_pkg::weight, {16'd0, w_buf[b]}, 1'b0);
                // act write commits the pair
                apb_write(neuron_pkg::act, {16'd0, a_buf[b]}, 1'b0);
            end
            apb_write(neuron_pkg::ctrl, 32'd1, 1'b0);
        end
    endtask

    // poll status, busy must stay up until done shows
    task wait_done;
        integer cycles;
        logic [31:0] st;
        begin
            cycles = 0;
            apb_read(neuron_pkg::status, st, 1'b0);
            while (st[1] !== 1'b1) begin
                assert (st[0] === 1'b1) else begin
                    $display("** Error: %0s status busy expected 1, actual %0d", cur_name, st[0]);
                    fail_stop();
                end
                if (cycles >= 200) begin
                    $display("run %0s did not finish within 200 cycles", cur_name);
                    fail_stop();
                end
                cycles = cycles + 2;
                apb_read(neuron_pkg::status, st, 1'b0);
            end
            assert (st[0] === 1'b0) else begin
                $display("** Error: %0s busy at done expected 0, actual %0d", cur_name, st[0]);
                fail_stop();
            end
        end
    endtask

    task check_result(input integer exp);
        logic [31:0] v;
        begin
            apb_read(neuron_pkg::sum, v, 1'b0);
            assert ($signed(v) == exp) else begin
                $display("** Error: %0s sum expected %0d, actual %0d", cur_name, exp, $signed(v));
                fail_stop();
            end
            apb_read(neuron_pkg::status, v, 1'b0);
            assert (v[2] == (exp < 0)) else begin
                $display("** Error: %0s sign expected %0d, actual %0d", cur_name, exp < 0, v[2]);
                fail_stop();
            end
        end
    endtask

    task do_run(input logic clr, input integer nb, input logic [15:0] mask);
        begin
            if (clr) begin
                model_acc = 0;
            end
            model_acc = model_acc + run_votes(nb, mask);
            load_run(clr, nb, mask);
            wait_done();
            check_result(model_acc);
        end
    endtask

    initial begin
        rst       = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = 8'd0;
        pwdata    = 32'd0;
        model_acc = 0;
        rng       = 32'hfc8;
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;

        // directed runs from the data file
        fd = $fopen("neuron_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open neuron_tests.txt");
            fail_stop();
        end
        while (!$feof(fd)) begin
            r = $fgets(line, fd);
            if (r != 0) begin
                cnt = $sscanf(line,
                    "%s %d %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %d %d",
                    cur_name, t_clear, t_nb, t_mask,
                    w_buf[0], a_buf[0], w_buf[1], a_buf[1],
                    w_buf[2], a_buf[2], w_buf[3], a_buf[3],
                    w_buf[4], a_buf[4], w_buf[5], a_buf[5],
                    w_buf[6], a_buf[6], w_buf[7], a_buf[7],
                    t_sum, t_sign);
                // comments and blank lines give one field or none
                if (cnt == 22) begin
                    exp_sum = ((t_clear != 0) ? 0 : model_acc) + run_votes(t_nb, t_mask);
                    assert (t_sum == exp_sum && t_sign == (exp_sum < 0)) else begin
                        $display("** Error: %0s file sum expected %0d, actual %0d",
                                 cur_name, exp_sum, t_sum);
                        fail_stop();
                    end
                    do_run(t_clear != 0, t_nb, t_mask);
                end else if (cnt > 1) begin
                    $display("malformed line in neuron_tests.txt, %0d fields", cnt);
                    fail_stop();
                end
            end
        end
        $fclose(fd);

        // writes during a run are refused and leave the result alone
        cur_name = "protocol";
        for (i = 0; i < 8; i = i + 1) begin
            w_buf[i] = 16'h0f0f ^ (16'h1111 * i[15:0]);
            a_buf[i] = 16'h00ff + i[15:0];
        end
        model_acc = run_votes(8, 16'hffff);
        load_run(1'b1, 8, 16'hffff);
        apb_read(neuron_pkg::status, rd, 1'b0);
        assert (rd[0] === 1'b1) else begin
            $display("** Error: %0s busy after start expected 1, actual %0d", cur_name, rd[0]);
            fail_stop();
        end
        // buf_addr stays writable mid-run, point it at beat 7
        apb_write(neuron_pkg::buf_addr, 32'd7, 1'b0);
        // beat 7 not read yet, a landed act would show in the sum
        apb_write(neuron_pkg::act, 32'h1234, 1'b1);
        // still streaming, a landed nbeats would stretch the run
        apb_write(neuron_pkg::nbeats, 32'd3, 1'b1);
        apb_write(neuron_pkg::ctrl, 32'd2, 1'b1);
        // last drain cycle, a landed start would rerun from done
        apb_write(neuron_pkg::ctrl, 32'd1, 1'b1);
        wait_done();
        check_result(model_acc);
        // unmapped offsets
        apb_read(8'h20, rd, 1'b1);
        apb_write(8'h24, 32'd0, 1'b1);

        // random runs, clear picked by the generator too
        cur_name = "random";
        for (r = 0; r < 20; r = r + 1) begin
            rng = lcg_next(rng);
            t_clear = rng[31];
            t_nb = 1 + rng[30:28];
            rng = lcg_next(rng);
            t_mask = rng[31:16];
            for (i = 0; i < 8; i = i + 1) begin
                rng = lcg_next(rng);
                w_buf[i] = rng[31:16];
                rng = lcg_next(rng);
                a_buf[i] = rng[31:16];
            end
            do_run(t_clear != 0, t_nb, t_mask);
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// ==== neuron_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module neuron_top (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            psel,
    input  wire                            penable,
    input  wire                            pwrite,
    input  wire  [neuron_pkg::apb_aw-1:0]  paddr,
    input  wire  [31:0]                    pwdata,
    output logic [31:0]                    prdata,
    output logic                           pready,
    output logic                           pslverr
);

    // register block to sequencer
    logic                               start;
    logic [3:0]                         nbeats;
    logic [neuron_pkg::lanes-1:0]       lane_mask;
    logic                               buf_we;
    logic [neuron_pkg::beat_aw-1:0]     buf_waddr;
    logic [neuron_pkg::lanes-1:0]       buf_weight;
    logic [neuron_pkg::lanes-1:0]       buf_act;
    logic                               busy;
    logic                               done;

    // register block to counter
    logic                               clear;
    logic                               sign;
    logic signed [neuron_pkg::acc_w-1:0] acc;

    // sequencer to counter
    logic [neuron_pkg::lanes-1:0]       store;
    logic [neuron_pkg::lanes-1:0]       core_result;

    apb_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .busy       (busy),
        .done       (done),
        .sign       (sign),
        .acc        (acc),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .start      (start),
        .clear      (clear),
        .nbeats     (nbeats),
        .lane_mask  (lane_mask),
        .buf_we     (buf_we),
        .buf_waddr  (buf_waddr),
        .buf_weight (buf_weight),
        .buf_act    (buf_act)
    );

    beat_sequencer u_seq (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .nbeats      (nbeats),
        .lane_mask   (lane_mask),
        .buf_we      (buf_we),
        .buf_waddr   (buf_waddr),
        .buf_weight  (buf_weight),
        .buf_act     (buf_act),
        .busy        (busy),
        .done        (done),
        .store       (store),
        .core_result (core_result)
    );

    vote_counter u_cnt (
        .clk         (clk),
        .rst         (rst),
        .clear       (clear),
        .store       (store),
        .core_result (core_result),
        .sign        (sign),
        .acc         (acc)
    );

endmodule

`default_nettype wire

// ==== apb_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module apb_regs (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 psel,
    input  wire                                 penable,
    input  wire                                 pwrite,
    input  wire  [neuron_pkg::apb_aw-1:0]       paddr,
    input  wire  [31:0]                         pwdata,
    input  wire                                 busy,
    input  wire                                 done,
    input  wire                                 sign,
    input  wire  signed [neuron_pkg::acc_w-1:0] acc,
    output logic [31:0]                         prdata,
    output logic                                pready,
    output logic                                pslverr,
    output logic                                start,
    output logic                                clear,
    output logic [3:0]                          nbeats,
    output logic [neuron_pkg::lanes-1:0]        lane_mask,
    output logic                                buf_we,
    output logic [neuron_pkg::beat_aw-1:0]      buf_waddr,
    output logic [neuron_pkg::lanes-1:0]        buf_weight,
    output logic [neuron_pkg::lanes-1:0]        buf_act
);

    neuron_pkg::reg_addr_e addr;

    // access phase decode
    logic access;
    logic wr;
    logic known;
    // writes that must not land while a run is going
    logic blocked;
    logic wr_ok;

    // done stays hidden after a clear until the next start
    logic done_hide;

    logic [neuron_pkg::beat_aw-1:0] buf_addr_q;

    assign addr   = neuron_pkg::reg_addr_e'(paddr);
    assign access = psel && penable;
    assign wr     = access && pwrite;

    always_comb begin
        known = 1'b1;
        case (addr)
            neuron_pkg::ctrl, neuron_pkg::nbeats, neuron_pkg::buf_addr,
            neuron_pkg::weight, neuron_pkg::act, neuron_pkg::mask,
            neuron_pkg::status, neuron_pkg::sum: known = 1'b1;
            default: known = 1'b0;
        endcase
    end

    assign blocked = busy && ((addr == neuron_pkg::ctrl && pwdata[1:0] != 2'b00) ||
                              addr == neuron_pkg::act || addr == neuron_pkg::nbeats);
    assign wr_ok   = wr && known && !blocked;

    // no wait states
    assign pready  = 1'b1;
    assign pslverr = access && (!known || (pwrite && blocked));

    // buffer commit in the act access cycle
    assign buf_we    = wr_ok && addr == neuron_pkg::act;
    assign buf_waddr = buf_addr_q;
    assign buf_act   = pwdata[neuron_pkg::lanes-1:0];

    // control registers
    always_ff @(posedge clk) begin
        if (rst) begin
            start      <= 1'b0;
            clear      <= 1'b0;
            nbeats     <= 4'd1;
            lane_mask  <= '1;
            buf_addr_q <= '0;
            done_hide  <= 1'b0;
        end else begin
            // ctrl bits become single-cycle pulses
            start <= wr_ok && addr == neuron_pkg::ctrl && pwdata[0];
            clear <= wr_ok && addr == neuron_pkg::ctrl && pwdata[1];
            if (clear) begin
                done_hide <= 1'b1;
            end else if (start) begin
                done_hide <= 1'b0;
            end
            if (wr_ok) begin
                case (addr)
                    neuron_pkg::nbeats: begin
                        // saturate into 1..8
                        if (pwdata == 32'd0) begin
                            nbeats <= 4'd1;
                        end else if (pwdata > 32'(neuron_pkg::max_beats)) begin
                            nbeats <= 4'(neuron_pkg::max_beats);
                        end else begin
                            nbeats <= pwdata[3:0];
                        end
                    end
                    neuron_pkg::buf_addr: buf_addr_q <= pwdata[neuron_pkg::beat_aw-1:0];
                    // wraps after the last entry
                    neuron_pkg::act:      buf_addr_q <= buf_addr_q + 1'b1;
                    neuron_pkg::mask:     lane_mask  <= pwdata[neuron_pkg::lanes-1:0];
                    default: ;
                endcase
            end
        end
    end

    // staged weight, payload only
    always_ff @(posedge clk) begin
        if (wr_ok && addr == neuron_pkg::weight) begin
            buf_weight <= pwdata[neuron_pkg::lanes-1:0];
        end
    end

    // read mux, ctrl and act read back as zero
    always_comb begin
        prdata = 32'd0;
        case (addr)
            neuron_pkg::nbeats:   prdata = {28'd0, nbeats};
            neuron_pkg::buf_addr: prdata = {{(32 - neuron_pkg::beat_aw){1'b0}}, buf_addr_q};
            neuron_pkg::weight:   prdata = {{(32 - neuron_pkg::lanes){1'b0}}, buf_weight};
            neuron_pkg::mask:     prdata = {{(32 - neuron_pkg::lanes){1'b0}}, lane_mask};
            neuron_pkg::status:   prdata = {29'd0, sign, done && !done_hide, busy};
            // accumulator sign-extended to the bus width
            neuron_pkg::sum:
                prdata = {{(32 - neuron_pkg::acc_w){acc[neuron_pkg::acc_w-1]}}, acc};
            default:              prdata = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

// ==== beat_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module beat_sequencer (
    input  wire                               clk,
    input  wire                               rst,
    input  wire                               start,
    input  wire  [3:0]                        nbeats,
    input  wire  [neuron_pkg::lanes-1:0]      lane_mask,
    input  wire                               buf_we,
    input  wire  [neuron_pkg::beat_aw-1:0]    buf_waddr,
    input  wire  [neuron_pkg::lanes-1:0]      buf_weight,
    input  wire  [neuron_pkg::lanes-1:0]      buf_act,
    output logic                              busy,
    output logic                              done,
    output logic [neuron_pkg::lanes-1:0]      store,
    output logic [neuron_pkg::lanes-1:0]      core_result
);

    // beat buffer, weight and activation pairs
    logic [neuron_pkg::lanes-1:0] weight_mem [neuron_pkg::max_beats];
    logic [neuron_pkg::lanes-1:0] act_mem [neuron_pkg::max_beats];

    neuron_pkg::seq_state_e state;

    // beat counter, index of the next beat to issue (0..8)
    logic [3:0] rd_ptr;

    // mask held for the whole run
    logic [neuron_pkg::lanes-1:0] run_mask;

    logic [neuron_pkg::drain_w-1:0] drain_cnt;

    // buffer read side
    logic [neuron_pkg::beat_aw-1:0] rd_idx;
    logic [neuron_pkg::lanes-1:0]   rd_xnor;

    // start accepted, beat 0 goes out next cycle
    logic launch;
    // some beat goes out next cycle
    logic issue;

    // host writes, one pair per act commit
    always_ff @(posedge clk) begin
        if (buf_we) begin
            weight_mem[buf_waddr] <= buf_weight;
            act_mem[buf_waddr]    <= buf_act;
        end
    end

    assign launch = start &&
                    (state == neuron_pkg::idle || state == neuron_pkg::done);
    assign issue  = launch || (state == neuron_pkg::stream && rd_ptr != nbeats);

    // entry 0 on launch, otherwise follow the beat counter
    assign rd_idx  = launch ? '0 : rd_ptr[neuron_pkg::beat_aw-1:0];
    // xnor lanes: 1 where weight and activation bits agree
    assign rd_xnor = ~(weight_mem[rd_idx] ^ act_mem[rd_idx]);

    // run fsm
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= neuron_pkg::idle;
            rd_ptr    <= '0;
            drain_cnt <= '0;
        end else begin
            case (state)
                neuron_pkg::idle, neuron_pkg::done: begin
                    if (start) begin
                        state  <= neuron_pkg::stream;
                        rd_ptr <= 4'd1;
                    end
                end
                neuron_pkg::stream: begin
                    if (rd_ptr == nbeats) begin
                        // last beat already out
                        state     <= neuron_pkg::drain;
                        drain_cnt <= '0;
                    end else begin
                        rd_ptr <= rd_ptr + 4'd1;
                    end
                end
                neuron_pkg::drain: begin
                    // wait for the last votes to land in the accumulator
                    if (drain_cnt == neuron_pkg::drain_w'(neuron_pkg::drain_cycles - 1)) begin
                        state <= neuron_pkg::done;
                    end else begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= neuron_pkg::idle;
                end
            endcase
        end
    end

    // store is the mask on an issued beat, zero otherwise
    always_ff @(posedge clk) begin
        if (rst) begin
            store <= '0;
        end else if (issue) begin
            store <= launch ? lane_mask : run_mask;
        end else begin
            store <= '0;
        end
    end

    // payload side, only meaningful where store is set
    always_ff @(posedge clk) begin
        if (launch) begin
            run_mask <= lane_mask;
        end
        if (issue) begin
            core_result <= rd_xnor;
        end
    end

    assign busy = (state == neuron_pkg::stream) || (state == neuron_pkg::drain);
    assign done = (state == neuron_pkg::done);

endmodule

`default_nettype wire

// ==== vote_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module vote_counter (
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire                                  clear,
    input  wire  [neuron_pkg::lanes-1:0]         store,
    input  wire  [neuron_pkg::lanes-1:0]         core_result,
    output logic                                 sign,
    output logic signed [neuron_pkg::acc_w-1:0]  acc
);

    // per lane votes, stage 1
    logic signed [1:0] vote [neuron_pkg::lanes];

    // combinational sum of all lane votes
    logic signed [neuron_pkg::sum_w-1:0] lane_sum;

    // registered sum, stage 2
    logic signed [neuron_pkg::sum_w-1:0] sum_q;

    // "any store" delayed to line up with sum_q
    logic store_d1;
    logic store_d2;

    // one selector per lane
    genvar k;
    generate
        for (k = 0; k < neuron_pkg::lanes; k = k + 1) begin : g_lane
            vote_selector u_sel (
                .clk             (clk),
                .store_bit       (store[k]),
                .core_result_bit (core_result[k]),
                .vote            (vote[k])
            );
        end
    endgenerate

    // any store bit marks a valid beat
    always_ff @(posedge clk) begin
        if (rst) begin
            store_d1 <= 1'b0;
            store_d2 <= 1'b0;
        end else begin
            store_d1 <= |store;
            store_d2 <= store_d1;
        end
    end

    // sign-extend each 2-bit vote and add them up
    always_comb begin
        lane_sum = '0;
        for (int i = 0; i < neuron_pkg::lanes; i++) begin
            lane_sum = lane_sum + {{(neuron_pkg::sum_w - 2){vote[i][1]}}, vote[i]};
        end
    end

    // vote adder register, new sum every cycle so back-to-back beats work
    always_ff @(posedge clk) begin
        sum_q <= lane_sum;
    end

    // accumulator, stage 3
    // only ever adds, a later run builds on the old total
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            acc <= '0;
        end else if (store_d2) begin
            acc <= acc + {{(neuron_pkg::acc_w - neuron_pkg::sum_w){sum_q[neuron_pkg::sum_w-1]}},
                          sum_q};
        end
    end

    // neuron activation, read straight off the top bit
    assign sign = acc[neuron_pkg::acc_w-1];

endmodule

`default_nettype wire

// ==== vote_selector.sv ====
`timescale 1ns/1ns
`default_nettype none

module vote_selector (
    input  wire               clk,
    input  wire               store_bit,
    input  wire               core_result_bit,
    output logic signed [1:0] vote
);

    // one lane: 0 when not stored, else +1 / -1 by the xnor result
    // no reset, the counter only looks at it behind a delayed store
    always_ff @(posedge clk) begin
        if (store_bit) begin
            if (core_result_bit) begin
                // weight and activation agree
                vote <= 2'sd1;
            end else begin
                // disagree
                vote <= -2'sd1;
            end
        end else begin
            // lane masked off or no beat
            vote <= 2'sd0;
        end
    end

endmodule

`default_nettype wire

// ==== neuron_pkg.sv ====
`default_nettype none

package neuron_pkg;

    // vote lanes per beat
    localparam int lanes = 16;

    // signed accumulator width
    localparam int acc_w = 30;

    // one cycle of lane votes, -16 to +16
    localparam int sum_w = 6;

    // beat buffer depth and its address width
    localparam int max_beats = 8;
    localparam int beat_aw = 3;

    // counter pipeline depth the sequencer waits out after the last beat
    localparam int drain_cycles = 3;
    localparam int drain_w = $clog2(drain_cycles + 1);

    // apb address width
    localparam int apb_aw = 8;

    // register offsets
    typedef enum logic [apb_aw-1:0] {
        // write only: bit 0 start, bit 1 clear
        ctrl     = 8'h00,
        nbeats   = 8'h04,
        buf_addr = 8'h08,
        // staged weight, committed by the act write
        weight   = 8'h0C,
        act      = 8'h10,
        mask     = 8'h14,
        // read only: bit 0 busy, bit 1 done, bit 2 sign
        status   = 8'h18,
        sum      = 8'h1C
    } reg_addr_e;

    // beat sequencer states
    typedef enum logic [1:0] {
        idle   = 2'd0,
        stream = 2'd1,
        drain  = 2'd2,
        done   = 2'd3
    } seq_state_e;

endpackage

`default_nettype wire
